// ==== design/obi_pkg.sv ====
// OBI 1P1 bus types only; one outstanding word width, no 1P2 fields, memory is word addressed
package obi_pkg;

  // ------------------------------------------------------------
  // Bus and memory sizes
  // ------------------------------------------------------------

  // Byte address width, covers the whole memory
  localparam int addr_w = 12;

  // Data bus width, four byte lanes
  localparam int data_w = 32;
  localparam int be_w = data_w / 8;

  // Word count, indexed by addr[11:2]
  localparam int mem_words = 1024;
  localparam int idx_w = $clog2(mem_words);

  // Edges from address acceptance to the rvalid sample
  localparam int resp_latency = 2;

  // ------------------------------------------------------------
  // Channel bundles
  // ------------------------------------------------------------

  // Address phase, driven by the requester
  typedef struct packed {
    logic              req;
    logic              we;
    logic [be_w-1:0]   be;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } obi_areq_t;

  // Response phase, no rready in 1P1
  typedef struct packed {
    logic              rvalid;
    logic [data_w-1:0] rdata;
  } obi_rsp_t;

endpackage

// ==== design/obi_check_pkg.sv ====
// Checker status types; flags are sticky and the counter assumes at most resp_latency in flight
package obi_check_pkg;

  // ------------------------------------------------------------
  // Outstanding transaction counter
  // ------------------------------------------------------------

  // Wide enough to show a runaway count well past the pipeline depth
  localparam int outst_w = 4;

  // ------------------------------------------------------------
  // Violation flags
  // ------------------------------------------------------------

  // One bit per protocol rule, MSB first
  typedef struct packed {
    // Address phase changed while waiting for gnt
    logic addr_unstable;
    logic we_unstable;
    logic wdata_unstable;
    logic be_unstable;
    // req went low before the grant came
    logic req_dropped;
    // rvalid with nothing accepted
    logic r_without_a;
    // Write byte enable encodings
    logic be_zero;
    logic be_gap;
  } obi_viol_t;

endpackage

// ==== design/obi_mem_responder.sv ====
// Grant follows stall only; lanes are written as given, contiguity is left to the checker
`timescale 1ns/1ps

module obi_mem_responder
  import obi_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  obi_areq_t areq,
  input  logic      stall,
  output logic      gnt,
  output obi_rsp_t  rsp
);

  // ------------------------------------------------------------
  // Address phase
  // ------------------------------------------------------------

  logic             accept;
  logic [idx_w-1:0] word_idx;

  // Memory is always ready unless held off from outside
  assign gnt = !stall;
  assign accept = areq.req && gnt;

  // Byte address down to word index, low two bits select lanes only
  assign word_idx = areq.addr[addr_w-1:addr_w-idx_w];

  // ------------------------------------------------------------
  // Storage and response data
  // ------------------------------------------------------------

  logic [data_w-1:0] mem [mem_words];

  // Two-stage response pipeline
  logic [1:0]        vld_q;
  logic [data_w-1:0] rdata_s0;
  logic [data_w-1:0] rdata_s1;

  // Write lanes and read capture share the acceptance edge
  // The read sees the word before this edge's write lanes
  always_ff @(posedge clk) begin
    if (accept) begin
      if (areq.we) begin
        for (int i = 0; i < be_w; i++) begin
          if (areq.be[i]) begin
            mem[word_idx][8*i +: 8] <= areq.wdata[8*i +: 8];
          end
        end
        // Write responses carry no data
        rdata_s0 <= '0;
      end else begin
        rdata_s0 <= mem[word_idx];
      end
    end
    // Second stage shifts unconditionally, qualified by vld_q[1]
    rdata_s1 <= rdata_s0;
  end

  // Valid bits shift alongside the data
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= accept;
      vld_q[1] <= vld_q[0];
    end
  end

  // No back-pressure on R, one cycle per response
  assign rsp.rvalid = vld_q[1];
  assign rsp.rdata  = rdata_s1;

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Every response traces back to an acceptance exactly resp_latency edges ago
  a_rvalid_latency: assert property (
    @(posedge clk) disable iff (!reset_n)
    rsp.rvalid |-> $past(accept, resp_latency)
  ) else $error("rvalid without acceptance %0d cycles earlier", resp_latency);

  // A write's response returns zero data
  a_write_rdata_zero: assert property (
    @(posedge clk) disable iff (!reset_n)
    rsp.rvalid && $past(areq.we, resp_latency) |-> rsp.rdata == '0
  ) else $error("write response with nonzero rdata 0x%08x", rsp.rdata);

endmodule

// ==== design/obi_protocol_checker.sv ====
// Passive 1P1 checker; field stability is judged only while req stays high, flags clear together
`timescale 1ns/1ps

module obi_protocol_checker
  import obi_pkg::*;
  import obi_check_pkg::*;
(
  input  logic               clk,
  input  logic               reset_n,
  input  obi_areq_t          areq,
  input  logic               gnt,
  input  obi_rsp_t           rsp,
  input  logic               viol_clear,
  output obi_viol_t          viol,
  output logic [outst_w-1:0] outstanding
);

  // ------------------------------------------------------------
  // Byte enable decode
  // ------------------------------------------------------------

  // Fill the trailing zeros, a single run of ones then adds up to a power of two
  function automatic logic be_is_contig(logic [be_w-1:0] be);
    logic [be_w:0] filled;
    filled = {1'b0, (be | (be - 1'b1))};
    return ((filled + 1'b1) & filled) == '0;
  endfunction

  // ------------------------------------------------------------
  // Previous cycle of the address phase
  // ------------------------------------------------------------

  logic      accept;
  logic      waiting_q;
  obi_areq_t areq_q;

  assign accept = areq.req && gnt;

  // Snapshot of last cycle's fields, only read when waiting_q is set
  always_ff @(posedge clk) begin
    areq_q <= areq;
  end

  // Request was pending without grant in the last cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      waiting_q <= 1'b0;
    end else begin
      waiting_q <= areq.req && !gnt;
    end
  end

  // ------------------------------------------------------------
  // Outstanding transactions
  // ------------------------------------------------------------

  logic [outst_w-1:0] outst_q;

  // Up on acceptance, down on response, both at once cancel
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      outst_q <= '0;
    end else if (accept && !rsp.rvalid) begin
      outst_q <= outst_q + 1'b1;
    end else if (!accept && rsp.rvalid) begin
      outst_q <= outst_q - 1'b1;
    end
  end

  assign outstanding = outst_q;

  // ------------------------------------------------------------
  // Rule evaluation
  // ------------------------------------------------------------

  obi_viol_t hit;
  obi_viol_t viol_q;
  logic      wr_req;

  assign wr_req = areq.req && areq.we;

  always_comb begin
    hit = '0;
    // Fields compared only if the request is still there; a drop is its own rule
    hit.addr_unstable  = waiting_q && areq.req && (areq.addr != areq_q.addr);
    hit.we_unstable    = waiting_q && areq.req && (areq.we != areq_q.we);
    hit.wdata_unstable = waiting_q && areq.req && (areq.wdata != areq_q.wdata);
    hit.be_unstable    = waiting_q && areq.req && (areq.be != areq_q.be);
    hit.req_dropped    = waiting_q && !areq.req;
    // Response with no accepted address in flight
    hit.r_without_a    = rsp.rvalid && (outst_q == '0);
    // Zero enables get their own flag, not a gap
    hit.be_zero        = wr_req && (areq.be == '0);
    hit.be_gap         = wr_req && (areq.be != '0) && !be_is_contig(areq.be);
  end

  // Sticky flags; a clear still keeps this cycle's hits
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      viol_q <= '0;
    end else if (viol_clear) begin
      viol_q <= hit;
    end else begin
      viol_q <= viol_q | hit;
    end
  end

  assign viol = viol_q;

  // ------------------------------------------------------------
  // Counter sanity
  // ------------------------------------------------------------

  // The responder pipeline never holds more than resp_latency items
  a_outst_bound: assert property (
    @(posedge clk) disable iff (!reset_n)
    outst_q <= outst_w'(resp_latency)
  ) else $error("outstanding count %0d above pipeline depth", outst_q);

  // Increment must grow the count, a wrap to zero would not
  a_outst_inc: assert property (
    @(posedge clk) disable iff (!reset_n)
    accept && !rsp.rvalid |=> outst_q > $past(outst_q)
  ) else $error("outstanding counter wrapped on increment");

  // Decrement must shrink the count
  a_outst_dec: assert property (
    @(posedge clk) disable iff (!reset_n)
    !accept && rsp.rvalid |=> outst_q < $past(outst_q)
  ) else $error("outstanding counter wrapped on decrement");

endmodule

// ==== design/obi_mem_top.sv ====
// Memory plus checker on one OBI 1P1 port; stall is the only source of back-pressure
`timescale 1ns/1ps

module obi_mem_top
  import obi_pkg::*;
  import obi_check_pkg::*;
(
  input  logic               clk,
  input  logic               reset_n,
  input  obi_areq_t          areq,
  input  logic               stall,
  output logic               gnt,
  output obi_rsp_t           rsp,
  input  logic               viol_clear,
  output obi_viol_t          viol,
  output logic [outst_w-1:0] outstanding
);

  // ------------------------------------------------------------
  // Memory responder
  // ------------------------------------------------------------

  // Owns gnt and the R channel
  obi_mem_responder u_responder (
    .clk     (clk),
    .reset_n (reset_n),
    .areq    (areq),
    .stall   (stall),
    .gnt     (gnt),
    .rsp     (rsp)
  );

  // ------------------------------------------------------------
  // Protocol checker
  // ------------------------------------------------------------

  // Watches the same wires the requester and responder see
  obi_protocol_checker u_checker (
    .clk         (clk),
    .reset_n     (reset_n),
    .areq        (areq),
    .gnt         (gnt),
    .rsp         (rsp),
    .viol_clear  (viol_clear),
    .viol        (viol),
    .outstanding (outstanding)
  );

endmodule

// ==== tb/tb_obi_model.svh ====
// Reference model state and rules; a read is only modeled for a word that was fully written first

// ------------------------------------------------------------
// Model state
// ------------------------------------------------------------

logic [data_w-1:0]  m_mem [mem_words];
logic               m_written [mem_words];
// Expected responses, due cycle and data side by side
int                 due_q [$];
logic [data_w-1:0]  data_q [$];
logic [outst_w-1:0] m_outst;
obi_viol_t          m_viol;
// Request pending without grant in the last cycle, and its fields
logic               m_wait;
obi_areq_t          m_prev;

task automatic model_reset();
  for (int i = 0; i < mem_words; i++) begin
    m_written[i] = 1'b0;
  end
  m_outst = '0;
  m_viol = '0;
  m_wait = 1'b0;
  m_prev = '0;
endtask

// Number of separate runs of set lanes, one for a legal write
function automatic int count_be_runs(logic [be_w-1:0] be);
  int runs;
  runs = 0;
  for (int i = 0; i < be_w; i++) begin
    if (be[i] && (i == 0 || !be[i-1])) runs++;
  end
  return runs;
endfunction

function automatic logic resp_due(int c);
  return (due_q.size() != 0) && (due_q[0] == c);
endfunction

// ------------------------------------------------------------
// One bus cycle, called with the inputs that the next edge samples
// ------------------------------------------------------------

task automatic model_advance(input int c, input logic rsp_now);
  logic      acc;
  int        idx;
  obi_viol_t hit;
  acc = areq.req && !stall;
  idx = int'(areq.addr[addr_w-1:2]);
  if (acc) begin
    // Response visible resp_latency cycles later
    due_q.push_back(c + resp_latency);
    if (areq.we) begin
      data_q.push_back('0);
      for (int i = 0; i < be_w; i++) begin
        if (areq.be[i]) m_mem[idx][8*i +: 8] = areq.wdata[8*i +: 8];
      end
      if (areq.be == 4'hf) m_written[idx] = 1'b1;
    end else begin
      data_q.push_back(m_mem[idx]);
    end
  end
  hit = '0;
  hit.addr_unstable  = m_wait && areq.req && (areq.addr != m_prev.addr);
  hit.we_unstable    = m_wait && areq.req && (areq.we != m_prev.we);
  hit.wdata_unstable = m_wait && areq.req && (areq.wdata != m_prev.wdata);
  hit.be_unstable    = m_wait && areq.req && (areq.be != m_prev.be);
  hit.req_dropped    = m_wait && !areq.req;
  hit.r_without_a    = rsp_now && (m_outst == '0);
  hit.be_zero        = areq.req && areq.we && (areq.be == '0);
  hit.be_gap         = areq.req && areq.we && (count_be_runs(areq.be) > 1);
  if (acc && !rsp_now) m_outst = m_outst + 1'b1;
  else if (!acc && rsp_now) m_outst = m_outst - 1'b1;
  // Clear drops old flags but keeps this cycle's hits
  m_viol = viol_clear ? hit : (m_viol | hit);
  m_wait = areq.req && stall;
  m_prev = areq;
endtask

// ==== tb/tb_obi_mem.sv ====
// Random OBI traffic from a fixed LFSR seed; reads target only fully written words in a 32-slot set
`timescale 1ns/1ps

module tb_obi_mem
  import obi_pkg::*;
  import obi_check_pkg::*;
();

  // ------------------------------------------------------------
  // Test lengths and run limit
  // ------------------------------------------------------------

  localparam int n_rand = 150;
  localparam int n_b2b = 40;
  localparam int n_stall = 80;
  localparam int n_inject = 7;
  // Worst case per op plus gaps, drains and a margin
  localparam int max_cycles = 10 + n_rand * 6 + n_b2b * 2 + n_stall * 20 + n_inject * 16 + 300;

  logic               clk;
  logic               reset_n;
  logic               stall;
  logic               viol_clear;
  logic               gnt;
  obi_areq_t          areq;
  obi_rsp_t           rsp;
  obi_viol_t          viol;
  logic [outst_w-1:0] outstanding;
  logic [outst_w-1:0] peak_outst;
  logic [31:0]        lfsr_state;
  logic               exp_v;
  int                 cyc;
  int                 errors;
  int                 err_start;
  int                 outst_err;
  int                 pass_n;
  int                 fail_n;

  `include "tb_obi_model.svh"

  obi_mem_top u_dut (
    .clk         (clk),
    .reset_n     (reset_n),
    .areq        (areq),
    .stall       (stall),
    .gnt         (gnt),
    .rsp         (rsp),
    .viol_clear  (viol_clear),
    .viol        (viol),
    .outstanding (outstanding)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Edge counter that also enforces the run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= max_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Random source
  // ------------------------------------------------------------

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Start lane plus run length give one contiguous run
  function automatic logic [be_w-1:0] rand_be();
    logic [1:0] start;
    logic [1:0] len;
    logic [7:0] run;
    start = 2'(take_bits(2));
    len = 2'(take_bits(2));
    run = ((8'h2 << len) - 8'h1) << start;
    return run[be_w-1:0];
  endfunction

  // Unwritten words get a full write before any read
  function automatic obi_areq_t rand_op();
    obi_areq_t        a;
    logic [idx_w-1:0] idx;
    a.req = 1'b1;
    a.addr = {5'(take_bits(5)), 5'h13, 2'b00};
    a.we = take_bits(1) != 0;
    a.be = rand_be();
    a.wdata = take_bits(32);
    idx = a.addr[addr_w-1:2];
    if (!m_written[idx]) begin
      a.we = 1'b1;
      a.be = 4'hf;
    end
    return a;
  endfunction

  // ------------------------------------------------------------
  // Bus driving tasks start and end 1 ns after an edge
  // ------------------------------------------------------------

  // Hold the request until an edge with gnt high
  task automatic send(input obi_areq_t a, input logic use_stall);
    logic s;
    s = 1'b1;
    while (s) begin
      s = use_stall ? (take_bits(1) != 0) : 1'b0;
      areq = a;
      stall = s;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic idle(input int n, input logic rand_stall);
    areq.req = 1'b0;
    stall = 1'b0;
    repeat (n) begin
      if (rand_stall) stall = take_bits(1) != 0;
      @(posedge clk);
      #1;
    end
  endtask

  // Idle until every expected response has been seen
  task automatic drain();
    idle(1, 1'b0);
    while (due_q.size() != 0) idle(1, 1'b0);
  endtask

  task automatic clear_flags();
    viol_clear = 1'b1;
    @(posedge clk);
    #1;
    viol_clear = 1'b0;
  endtask

  task automatic expect_viol(input obi_viol_t exp);
    assert (viol == exp) else begin
      $display("Fail viol got 0x%02h exp 0x%02h", viol, exp);
      errors++;
    end
  endtask

  task automatic begin_test();
    err_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == err_start) begin
      pass_n++;
      $display("test %s: ok", name);
    end else begin
      fail_n++;
      $display("test %s: %0d errors", name, errors - err_start);
    end
  endtask

  // One rule broken on a write followed by drain, check and clear
  task automatic inject(input int kind);
    obi_areq_t a;
    obi_areq_t b;
    obi_viol_t exp;
    string     name;
    begin_test();
    a.req = 1'b1;
    a.we = 1'b1;
    a.be = 4'hf;
    a.addr = {5'(take_bits(5)), 5'h0c, 2'b00};
    a.wdata = take_bits(32);
    b = a;
    exp = '0;
    case (kind)
      0: begin
        b.addr = a.addr ^ 12'h080;
        exp.addr_unstable = 1'b1;
        name = "addr change";
      end
      1: begin
        a.we = 1'b0;
        exp.we_unstable = 1'b1;
        name = "we change";
      end
      2: begin
        b.wdata = a.wdata ^ 32'h0000_0100;
        exp.wdata_unstable = 1'b1;
        name = "wdata change";
      end
      3: begin
        b.be = 4'h3;
        exp.be_unstable = 1'b1;
        name = "be change";
      end
      4: begin
        exp.req_dropped = 1'b1;
        name = "req dropped";
      end
      5: begin
        a.be = 4'h0;
        exp.be_zero = 1'b1;
        name = "be zero";
      end
      default: begin
        a.be = 4'b0101;
        exp.be_gap = 1'b1;
        name = "be gap";
      end
    endcase
    // Stability rules need one cycle of waiting first
    if (kind <= 4) begin
      areq = a;
      stall = 1'b1;
      @(posedge clk);
      #1;
    end
    if (kind == 4) idle(1, 1'b0);
    else if (kind < 4) send(b, 1'b0);
    else send(a, 1'b0);
    drain();
    expect_viol(exp);
    clear_flags();
    expect_viol('0);
    end_test(name);
  endtask

  // ------------------------------------------------------------
  // Monitor sampling at the falling edge where all outputs are settled
  // ------------------------------------------------------------

  always @(negedge clk) begin
    if (reset_n) begin
      exp_v = resp_due(cyc);
      assert (rsp.rvalid == exp_v) else begin
        $display("Fail rvalid got 0x%0h exp 0x%0h at cycle %0d", rsp.rvalid, exp_v, cyc);
        errors++;
      end
      if (exp_v) begin
        if (rsp.rvalid) begin
          assert (rsp.rdata == data_q[0]) else begin
            $display("Fail rdata got 0x%08h exp 0x%08h", rsp.rdata, data_q[0]);
            errors++;
          end
        end
        void'(due_q.pop_front());
        void'(data_q.pop_front());
      end
      assert (outstanding == m_outst) else begin
        $display("Fail outstanding got 0x%0h exp 0x%0h", outstanding, m_outst);
        errors++;
        outst_err++;
      end
      assert (viol == m_viol) else begin
        $display("Fail viol got 0x%02h exp 0x%02h", viol, m_viol);
        errors++;
      end
      assert (gnt == !stall) else begin
        $display("Fail gnt got 0x%0h exp 0x%0h", gnt, !stall);
        errors++;
      end
      if (outstanding > peak_outst) peak_outst = outstanding;
      model_advance(cyc, exp_v);
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    areq = '0;
    stall = 1'b0;
    viol_clear = 1'b0;
    reset_n = 1'b0;
    lfsr_state = 32'h3971_dbea;
    errors = 0;
    err_start = 0;
    outst_err = 0;
    pass_n = 0;
    fail_n = 0;
    peak_outst = '0;
    model_reset();
    repeat (10) @(posedge clk);
    #1;
    reset_n = 1'b1;

    // Legal mix with random gaps and no stall
    begin_test();
    repeat (n_rand) begin
      send(rand_op(), 1'b0);
      idle(int'(take_bits(2)), 1'b0);
    end
    drain();
    end_test("random read/write");

    // Back to back with two in flight
    begin_test();
    peak_outst = '0;
    repeat (n_b2b) send(rand_op(), 1'b0);
    drain();
    assert (peak_outst == outst_w'(resp_latency)) else begin
      $display("Fail outstanding peak got 0x%0h exp 0x%0h", peak_outst, resp_latency);
      errors++;
    end
    end_test("back to back");

    // Random stall with requests held until granted
    begin_test();
    repeat (n_stall) begin
      send(rand_op(), 1'b1);
      idle(int'(take_bits(1)), 1'b1);
    end
    drain();
    expect_viol('0);
    end_test("random stall");

    // Counter tracked the model on every cycle so far
    begin_test();
    assert (outst_err == 0) else begin
      $display("outstanding differed from the model on %0d cycles", outst_err);
      errors++;
    end
    assert (outstanding == '0) else begin
      $display("Fail outstanding got 0x%0h exp 0x0", outstanding);
      errors++;
    end
    end_test("outstanding count");

    for (int k = 0; k < n_inject; k++) begin
      inject(k);
    end

    $display("summary: %0d tests passed, %0d tests failed, %0d check errors",
             pass_n, fail_n, errors);
    if (fail_n == 0 && errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+tb
design/obi_pkg.sv
design/obi_check_pkg.sv
design/obi_mem_responder.sv
design/obi_protocol_checker.sv
design/obi_mem_top.sv
tb/tb_obi_mem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for failure
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_obi_mem \
  --Mdir build/obj -o tb_obi_mem \
  -f compile.f

# A crashed run still leaves a log to inspect
./build/obj/tb_obi_mem 2>&1 | tee build/sim.log

if grep -q "Regression failed" build/sim.log; then
  echo "simulation reported a failure, see build/sim.log"
  exit 1
fi

if ! grep -q "Regression passed" build/sim.log; then
  echo "simulation ended without a pass line, see build/sim.log"
  exit 1
fi

exit 0
